// File: verilog/opm_reg_pkg.sv
`default_nettype none

package opm_reg_pkg;

    ////////////////////////////////////////
    // bus

    localparam int BUS_W = 8;

    ////////////////////////////////////////
    // global register addresses

    localparam logic [BUS_W-1:0] ADDR_NOISE      = 8'h0F; // NE, NFRQ
    localparam logic [BUS_W-1:0] ADDR_CLKA1      = 8'h10; // timer A upper 8 bits
    localparam logic [BUS_W-1:0] ADDR_CLKA2      = 8'h11; // timer A lower 2 bits
    localparam logic [BUS_W-1:0] ADDR_CLKB       = 8'h12;
    localparam logic [BUS_W-1:0] ADDR_TIMER_CTRL = 8'h14;
    localparam logic [BUS_W-1:0] ADDR_LFRQ       = 8'h18;
    localparam logic [BUS_W-1:0] ADDR_LFO_DEPTH  = 8'h19; // PMD or AMD, see lfo_depth_u
    localparam logic [BUS_W-1:0] ADDR_WAVE       = 8'h1B;

    // channel blocks, matched against addr[7:3]
    // addr[2:0] is the channel number
    localparam logic [4:0] CH_RL_FL_ALG = 5'b00100; // 0x20
    localparam logic [4:0] CH_KC        = 5'b00101; // 0x28
    localparam logic [4:0] CH_KF        = 5'b00110; // 0x30
    localparam logic [4:0] CH_PMS_AMS   = 5'b00111; // 0x38

    ////////////////////////////////////////
    // field widths

    localparam int KC_W    = 7;
    localparam int KF_W    = 6;
    localparam int ALG_W   = 3;
    localparam int FL_W    = 3;
    localparam int RL_W    = 2;
    localparam int PMS_W   = 3;
    localparam int AMS_W   = 2;
    localparam int NFRQ_W  = 5;
    localparam int DEPTH_W = 7;

    // defaults for the top level parameters
    localparam int DEF_BUSY_CYCLES = 32;
    localparam int DEF_NUM_CH      = 8;

    // data byte of 0x19, one LFO depth with a select bit on top
    // sel high -> PMD, sel low -> AMD
    typedef union packed {
        struct packed {
            logic               sel;
            logic [DEPTH_W-1:0] pmd;
        } pm;
        struct packed {
            logic               sel;
            logic [DEPTH_W-1:0] amd;
        } am;
    } lfo_depth_u;

endpackage

`default_nettype wire

// File: verilog/opm_wr_if.sv
`default_nettype none

// synchronized host writes, one strobe per completed write
interface opm_wr_if;

    logic [opm_reg_pkg::BUS_W-1:0] wr_addr; // last address byte, held
    logic [opm_reg_pkg::BUS_W-1:0] wr_data; // last data byte, held
    logic                          addr_ld;
    logic                          data_ld;

    modport src (
        output wr_addr,
        output wr_data,
        output addr_ld,
        output data_ld
    );

    modport dst (
        input  wr_addr,
        input  wr_data,
        input  addr_ld,
        input  data_ld
    );

endinterface

`default_nettype wire

// File: verilog/opm_bus_sync.sv
`default_nettype none

module opm_bus_sync #(
    parameter int BUSY_CYCLES = opm_reg_pkg::DEF_BUSY_CYCLES
) (
    input  wire                           i_EMUCLK,
    input  wire                           mrst_n,
    input  wire                           i_cs_n,
    input  wire                           i_wr_n,
    input  wire                           i_a0,
    input  wire [opm_reg_pkg::BUS_W-1:0]  i_d,
    opm_wr_if.src                         wr,
    output logic                          o_busy
);

    localparam int CNT_W = $clog2(BUSY_CYCLES + 1);

    logic [1:0]                    cs_n_s;
    logic [1:0]                    wr_n_s;
    logic [1:0]                    a0_s;
    logic [opm_reg_pkg::BUS_W-1:0] d_s1;
    logic [opm_reg_pkg::BUS_W-1:0] d_s2;
    logic                          wr_act;
    logic                          wr_act_d;
    logic                          wr_start;
    logic                          addr_ld_r;
    logic                          data_ld_r;
    logic [CNT_W-1:0]              busy_cnt;

    ////////////////////////////////////////
    // two-stage pin synchronizer

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            cs_n_s <= 2'b11; // pins idle high
            wr_n_s <= 2'b11;
            a0_s   <= 2'b00;
        end else begin
            cs_n_s <= {cs_n_s[0], i_cs_n};
            wr_n_s <= {wr_n_s[0], i_wr_n};
            a0_s   <= {a0_s[0], i_a0};
        end
    end

    // data byte follows the same two stages
    always_ff @(posedge i_EMUCLK) begin
        d_s1 <= i_d;
        d_s2 <= d_s1;
    end

    // first cycle of CS and WR both low
    assign wr_act   = ~cs_n_s[1] & ~wr_n_s[1];
    assign wr_start = wr_act & ~wr_act_d;

    ////////////////////////////////////////
    // strobes and held address

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            wr_act_d    <= 1'b0;
            addr_ld_r   <= 1'b0;
            data_ld_r   <= 1'b0;
            wr.wr_addr  <= 8'hFF; // decodes to nothing
        end else begin
            wr_act_d  <= wr_act;
            addr_ld_r <= wr_start & ~a0_s[1];
            data_ld_r <= wr_start & a0_s[1];
            if (wr_start && !a0_s[1]) begin
                wr.wr_addr <= d_s2;
            end
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        if (wr_start && a0_s[1]) begin
            wr.wr_data <= d_s2;
        end
    end

    assign wr.addr_ld = addr_ld_r;
    assign wr.data_ld = data_ld_r;

    ////////////////////////////////////////
    // write busy timer, restarts on every data write

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            busy_cnt <= '0;
        end else if (data_ld_r) begin
            busy_cnt <= CNT_W'(BUSY_CYCLES);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign o_busy = (busy_cnt != '0);

endmodule

`default_nettype wire

// File: verilog/opm_global_regs.sv
`default_nettype none

module opm_global_regs (
    input  wire                                 i_EMUCLK,
    input  wire                                 mrst_n,
    opm_wr_if.dst                               wr,

    output logic                                o_ne,
    output logic [opm_reg_pkg::NFRQ_W-1:0]      o_nfrq,

    output logic [opm_reg_pkg::BUS_W-1:0]       o_clka1,
    output logic [1:0]                          o_clka2,
    output logic [opm_reg_pkg::BUS_W-1:0]       o_clkb,
    output logic                                o_timera_run,
    output logic                                o_timerb_run,
    output logic                                o_timera_irq_en,
    output logic                                o_timerb_irq_en,
    output logic                                o_timera_frst,
    output logic                                o_timerb_frst,

    output logic [opm_reg_pkg::BUS_W-1:0]       o_lfrq,
    output logic                                o_lfrq_update,
    output logic [opm_reg_pkg::DEPTH_W-1:0]     o_pmd,
    output logic [opm_reg_pkg::DEPTH_W-1:0]     o_amd,
    output logic [1:0]                          o_w
);

    opm_reg_pkg::lfo_depth_u depth;

    assign depth = wr.wr_data; // only meaningful for 0x19

    ////////////////////////////////////////
    // decode on data_ld, update one cycle later

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            o_ne            <= 1'b0;
            o_nfrq          <= '0;
            o_clka1         <= '0;
            o_clka2         <= '0;
            o_clkb          <= '0;
            o_timera_run    <= 1'b0;
            o_timerb_run    <= 1'b0;
            o_timera_irq_en <= 1'b0;
            o_timerb_irq_en <= 1'b0;
            o_timera_frst   <= 1'b0;
            o_timerb_frst   <= 1'b0;
            o_lfrq          <= '0;
            o_lfrq_update   <= 1'b0;
            o_pmd           <= '0;
            o_amd           <= '0;
            o_w             <= '0;
        end else begin
            // single cycle pulses
            o_timera_frst <= 1'b0;
            o_timerb_frst <= 1'b0;
            o_lfrq_update <= 1'b0;

            if (wr.data_ld) begin
                case (wr.wr_addr)
                    opm_reg_pkg::ADDR_NOISE: begin
                        o_ne   <= wr.wr_data[7];
                        o_nfrq <= wr.wr_data[opm_reg_pkg::NFRQ_W-1:0];
                    end
                    opm_reg_pkg::ADDR_CLKA1: o_clka1 <= wr.wr_data;
                    opm_reg_pkg::ADDR_CLKA2: o_clka2 <= wr.wr_data[1:0];
                    opm_reg_pkg::ADDR_CLKB:  o_clkb  <= wr.wr_data;
                    opm_reg_pkg::ADDR_TIMER_CTRL: begin
                        o_timera_run    <= wr.wr_data[0];
                        o_timerb_run    <= wr.wr_data[1];
                        o_timera_irq_en <= wr.wr_data[2];
                        o_timerb_irq_en <= wr.wr_data[3];
                        o_timera_frst   <= wr.wr_data[4]; // flag clear requests
                        o_timerb_frst   <= wr.wr_data[5];
                    end
                    opm_reg_pkg::ADDR_LFRQ: begin
                        o_lfrq        <= wr.wr_data;
                        o_lfrq_update <= 1'b1; // lets the LFO reload its rate
                    end
                    opm_reg_pkg::ADDR_LFO_DEPTH: begin
                        if (depth.pm.sel) begin
                            o_pmd <= depth.pm.pmd;
                        end else begin
                            o_amd <= depth.am.amd;
                        end
                    end
                    opm_reg_pkg::ADDR_WAVE: o_w <= wr.wr_data[1:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/opm_channel_regs.sv
`default_nettype none

module opm_channel_regs #(
    parameter int NUM_CH = opm_reg_pkg::DEF_NUM_CH
) (
    input  wire                                 i_EMUCLK,
    input  wire                                 mrst_n,
    opm_wr_if.dst                               wr,

    output logic [2:0]                          o_slot,
    output logic [opm_reg_pkg::KC_W-1:0]        o_kc,
    output logic [opm_reg_pkg::KF_W-1:0]        o_kf,
    output logic [opm_reg_pkg::ALG_W-1:0]       o_alg,
    output logic [opm_reg_pkg::FL_W-1:0]        o_fl,
    output logic [opm_reg_pkg::RL_W-1:0]        o_rl,
    output logic [opm_reg_pkg::PMS_W-1:0]       o_pms,
    output logic [opm_reg_pkg::AMS_W-1:0]       o_ams
);

    // one stage word, fields ordered {rl, fl, alg, kc, kf, pms, ams}
    localparam int CH_W = opm_reg_pkg::RL_W + opm_reg_pkg::FL_W + opm_reg_pkg::ALG_W
                        + opm_reg_pkg::KC_W + opm_reg_pkg::KF_W
                        + opm_reg_pkg::PMS_W + opm_reg_pkg::AMS_W;

    logic                          is_ch;
    logic                          ch_valid;  // held address is a channel register
    logic                          ch_pend;   // data waiting for its slot
    logic [opm_reg_pkg::BUS_W-1:0] ch_addr;
    logic [opm_reg_pkg::BUS_W-1:0] ch_data;
    logic [2:0]                    slot_cnt;
    logic                          ch_load;
    logic                          en_20;
    logic                          en_28;
    logic                          en_30;
    logic                          en_38;
    logic [CH_W-1:0]               ch_mask;
    logic [CH_W-1:0]               ch_ins;
    logic [CH_W-1:0]               ch_next;
    logic [CH_W-1:0]               ch_sr [NUM_CH];

    ////////////////////////////////////////
    // temporary address and data

    assign is_ch = wr.wr_addr[7:3] inside {opm_reg_pkg::CH_RL_FL_ALG, opm_reg_pkg::CH_KC,
                                           opm_reg_pkg::CH_KF, opm_reg_pkg::CH_PMS_AMS};

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            ch_valid <= 1'b0;
            ch_pend  <= 1'b0;
        end else if (wr.addr_ld) begin
            ch_valid <= is_ch;
            ch_pend  <= 1'b0; // new address drops any unloaded data
        end else if (wr.data_ld && ch_valid) begin
            ch_pend  <= 1'b1;
        end else if (ch_load) begin
            ch_pend  <= 1'b0;
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        if (wr.addr_ld) begin
            ch_addr <= wr.wr_addr;
        end
        if (wr.data_ld && ch_valid) begin
            ch_data <= wr.wr_data;
        end
    end

    ////////////////////////////////////////
    // slot counter, o_slot names the channel in stage 0

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            slot_cnt <= '0;
            o_slot   <= '0;
        end else begin
            slot_cnt <= (slot_cnt == 3'(NUM_CH - 1)) ? 3'd0 : slot_cnt + 3'd1;
            o_slot   <= slot_cnt;
        end
    end

    assign ch_load = ch_pend & (ch_addr[2:0] == slot_cnt);

    // which fields the pending byte replaces
    assign en_20 = (ch_addr[7:3] == opm_reg_pkg::CH_RL_FL_ALG);
    assign en_28 = (ch_addr[7:3] == opm_reg_pkg::CH_KC);
    assign en_30 = (ch_addr[7:3] == opm_reg_pkg::CH_KF);
    assign en_38 = (ch_addr[7:3] == opm_reg_pkg::CH_PMS_AMS);

    assign ch_mask = {{opm_reg_pkg::RL_W{en_20}}, {opm_reg_pkg::FL_W{en_20}},
                      {opm_reg_pkg::ALG_W{en_20}}, {opm_reg_pkg::KC_W{en_28}},
                      {opm_reg_pkg::KF_W{en_30}}, {opm_reg_pkg::PMS_W{en_38}},
                      {opm_reg_pkg::AMS_W{en_38}}};

    // bit positions of each field in its data byte
    assign ch_ins = {ch_data[7:6], ch_data[5:3], ch_data[2:0], ch_data[6:0],
                     ch_data[7:2], ch_data[6:4], ch_data[1:0]};

    ////////////////////////////////////////
    // recirculating channel shift register

    assign ch_next = ch_load ? ((ch_sr[NUM_CH-1] & ~ch_mask) | (ch_ins & ch_mask))
                             : ch_sr[NUM_CH-1];

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                ch_sr[i] <= '0;
            end
        end else begin
            ch_sr[0] <= ch_next;
            for (int i = 1; i < NUM_CH; i++) begin
                ch_sr[i] <= ch_sr[i-1];
            end
        end
    end

    // common tap for all fields
    assign {o_rl, o_fl, o_alg, o_kc, o_kf, o_pms, o_ams} = ch_sr[0];

endmodule

`default_nettype wire

// File: verilog/opm_reg.sv
`default_nettype none

module opm_reg #(
    parameter int BUSY_CYCLES = opm_reg_pkg::DEF_BUSY_CYCLES,
    parameter int NUM_CH      = opm_reg_pkg::DEF_NUM_CH
) (
    input  wire                                 i_EMUCLK,
    input  wire                                 mrst_n,

    // host bus
    input  wire                                 i_cs_n,
    input  wire                                 i_rd_n,
    input  wire                                 i_wr_n,
    input  wire                                 i_a0,
    input  wire [opm_reg_pkg::BUS_W-1:0]        i_d,
    output wire [opm_reg_pkg::BUS_W-1:0]        o_d,
    output wire                                 o_d_oe,

    input  wire                                 i_timera_flag,
    input  wire                                 i_timerb_flag,

    // global registers
    output wire                                 o_ne,
    output wire [opm_reg_pkg::NFRQ_W-1:0]       o_nfrq,
    output wire [opm_reg_pkg::BUS_W-1:0]        o_clka1,
    output wire [1:0]                           o_clka2,
    output wire [opm_reg_pkg::BUS_W-1:0]        o_clkb,
    output wire                                 o_timera_run,
    output wire                                 o_timerb_run,
    output wire                                 o_timera_irq_en,
    output wire                                 o_timerb_irq_en,
    output wire                                 o_timera_frst,
    output wire                                 o_timerb_frst,
    output wire [opm_reg_pkg::BUS_W-1:0]        o_lfrq,
    output wire                                 o_lfrq_update,
    output wire [opm_reg_pkg::DEPTH_W-1:0]      o_pmd,
    output wire [opm_reg_pkg::DEPTH_W-1:0]      o_amd,
    output wire [1:0]                           o_w,

    // per-channel registers
    output wire [2:0]                           o_slot,
    output wire [opm_reg_pkg::KC_W-1:0]         o_kc,
    output wire [opm_reg_pkg::KF_W-1:0]         o_kf,
    output wire [opm_reg_pkg::ALG_W-1:0]        o_alg,
    output wire [opm_reg_pkg::FL_W-1:0]         o_fl,
    output wire [opm_reg_pkg::RL_W-1:0]         o_rl,
    output wire [opm_reg_pkg::PMS_W-1:0]        o_pms,
    output wire [opm_reg_pkg::AMS_W-1:0]        o_ams
);

    logic                          busy;
    logic [opm_reg_pkg::BUS_W-1:0] status;

    opm_wr_if wr_bus ();

    opm_bus_sync #(
        .BUSY_CYCLES (BUSY_CYCLES)
    ) u_bus_sync (
        .i_EMUCLK (i_EMUCLK),
        .mrst_n   (mrst_n),
        .i_cs_n   (i_cs_n),
        .i_wr_n   (i_wr_n),
        .i_a0     (i_a0),
        .i_d      (i_d),
        .wr       (wr_bus.src),
        .o_busy   (busy)
    );

    opm_global_regs u_global_regs (
        .i_EMUCLK        (i_EMUCLK),
        .mrst_n          (mrst_n),
        .wr              (wr_bus.dst),
        .o_ne            (o_ne),
        .o_nfrq          (o_nfrq),
        .o_clka1         (o_clka1),
        .o_clka2         (o_clka2),
        .o_clkb          (o_clkb),
        .o_timera_run    (o_timera_run),
        .o_timerb_run    (o_timerb_run),
        .o_timera_irq_en (o_timera_irq_en),
        .o_timerb_irq_en (o_timerb_irq_en),
        .o_timera_frst   (o_timera_frst),
        .o_timerb_frst   (o_timerb_frst),
        .o_lfrq          (o_lfrq),
        .o_lfrq_update   (o_lfrq_update),
        .o_pmd           (o_pmd),
        .o_amd           (o_amd),
        .o_w             (o_w)
    );

    opm_channel_regs #(
        .NUM_CH (NUM_CH)
    ) u_channel_regs (
        .i_EMUCLK (i_EMUCLK),
        .mrst_n   (mrst_n),
        .wr       (wr_bus.dst),
        .o_slot   (o_slot),
        .o_kc     (o_kc),
        .o_kf     (o_kf),
        .o_alg    (o_alg),
        .o_fl     (o_fl),
        .o_rl     (o_rl),
        .o_pms    (o_pms),
        .o_ams    (o_ams)
    );

    ////////////////////////////////////////
    // status read

    assign status = {busy, 5'b00000, i_timerb_flag, i_timera_flag};
    assign o_d    = status;
    assign o_d_oe = mrst_n & ~i_cs_n & ~i_rd_n & ~i_a0; // A0 low reads status

endmodule

`default_nettype wire

// File: tests/opm_reg_chk.sv
`default_nettype none

module opm_reg_chk #(
    parameter int BUSY_CYCLES = opm_reg_pkg::DEF_BUSY_CYCLES,
    parameter int NUM_CH      = opm_reg_pkg::DEF_NUM_CH
) (
    input wire       i_EMUCLK,
    input wire       mrst_n,
    input wire       i_addr_ld,
    input wire       i_data_ld,
    input wire       i_busy,
    input wire [2:0] i_slot
);

    int since_data; // cycles since the last data strobe, saturating
    int fail_cnt = 0; // failed assertions so far

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            since_data <= BUSY_CYCLES + 2;
        end else if (i_data_ld) begin
            since_data <= 0;
        end else if (since_data < BUSY_CYCLES + 2) begin
            since_data <= since_data + 1;
        end
    end

    ////////////////////////////////////////
    // strobes

    a_addr_one: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        i_addr_ld |=> !i_addr_ld)
        else begin
            $error("addr_ld held longer than one cycle");
            fail_cnt++;
        end

    a_data_one: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        i_data_ld |=> !i_data_ld)
        else begin
            $error("data_ld held longer than one cycle");
            fail_cnt++;
        end

    a_excl: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        !(i_addr_ld && i_data_ld))
        else begin
            $error("addr_ld and data_ld high together");
            fail_cnt++;
        end

    // o_slot lags the counter by one, so skip two edges after reset
    a_slot: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        ($past(mrst_n) && $past(mrst_n, 2)) |->
        i_slot == (($past(i_slot) == 3'(NUM_CH - 1)) ? 3'd0 : $past(i_slot) + 3'd1))
        else begin
            $error("slot counter did not advance by one");
            fail_cnt++;
        end

    a_busy: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        i_busy |-> since_data <= BUSY_CYCLES + 1)
        else begin
            $error("busy held too long after the last data write");
            fail_cnt++;
        end

endmodule

bind opm_reg opm_reg_chk #(
    .BUSY_CYCLES (BUSY_CYCLES),
    .NUM_CH      (NUM_CH)
) u_chk (
    .i_EMUCLK  (i_EMUCLK),
    .mrst_n    (mrst_n),
    .i_addr_ld (wr_bus.addr_ld),
    .i_data_ld (wr_bus.data_ld),
    .i_busy    (busy),
    .i_slot    (o_slot)
);

`default_nettype wire

// File: tests/opm_reg_tb.sv
`default_nettype none

module opm_reg_tb;

    localparam int NUM_CH      = opm_reg_pkg::DEF_NUM_CH;
    localparam int BUSY_CYCLES = opm_reg_pkg::DEF_BUSY_CYCLES;
    localparam int BW          = opm_reg_pkg::BUS_W;
    localparam int FW          = opm_reg_pkg::DEPTH_W;
    localparam logic [BW-1:0] SEL_AMD = 8'h1A; // check id for o_amd
    localparam logic [BW-1:0] SEL_OE  = 8'hD0; // check id for o_d_oe

    logic i_EMUCLK, mrst_n, i_cs_n, i_rd_n, i_wr_n, i_a0, i_timera_flag, i_timerb_flag;
    logic [BW-1:0] i_d, o_d, o_clka1, o_clkb, o_lfrq;
    logic o_d_oe, o_ne, o_timera_run, o_timerb_run, o_timera_irq_en, o_timerb_irq_en;
    logic o_timera_frst, o_timerb_frst, o_lfrq_update;
    logic [opm_reg_pkg::NFRQ_W-1:0] o_nfrq;
    logic [1:0] o_clka2, o_w;
    logic [FW-1:0] o_pmd, o_amd;
    logic [2:0] o_slot;
    logic [opm_reg_pkg::KC_W-1:0] o_kc;
    logic [opm_reg_pkg::KF_W-1:0] o_kf;
    logic [opm_reg_pkg::ALG_W-1:0] o_alg;
    logic [opm_reg_pkg::FL_W-1:0] o_fl;
    logic [opm_reg_pkg::RL_W-1:0] o_rl;
    logic [opm_reg_pkg::PMS_W-1:0] o_pms;
    logic [opm_reg_pkg::AMS_W-1:0] o_ams;

    // expected channel contents
    logic [opm_reg_pkg::KC_W-1:0]  m_kc  [NUM_CH];
    logic [opm_reg_pkg::KF_W-1:0]  m_kf  [NUM_CH];
    logic [opm_reg_pkg::ALG_W-1:0] m_alg [NUM_CH];
    logic [opm_reg_pkg::FL_W-1:0]  m_fl  [NUM_CH];
    logic [opm_reg_pkg::RL_W-1:0]  m_rl  [NUM_CH];
    logic [opm_reg_pkg::PMS_W-1:0] m_pms [NUM_CH];
    logic [opm_reg_pkg::AMS_W-1:0] m_ams [NUM_CH];

    string         cmd_q [$];
    logic [BW-1:0] a_q [$];
    logic [BW-1:0] v_q [$];
    logic [BW-1:0] e_q [$];
    int mismatches, other_errors, cycles, limit, seed;
    int cnt_frsta, cnt_frstb, cnt_lfrq, base_frsta, base_frstb, base_lfrq;

    opm_reg #(.BUSY_CYCLES(BUSY_CYCLES), .NUM_CH(NUM_CH)) uut (.*);

    initial i_EMUCLK = 1'b0;
    always #10 i_EMUCLK = ~i_EMUCLK;

    ////////////////////////////////////////
    // pulse counters and timeout

    always @(posedge i_EMUCLK) begin
        if (o_timera_frst) cnt_frsta++;
        if (o_timerb_frst) cnt_frstb++;
        if (o_lfrq_update) cnt_lfrq++;
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_byte(input string name, input logic [BW-1:0] got, exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_field(input string name, input logic [FW-1:0] got, exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    // one bus cycle, WR low 4 cycles then 6 idle
    task automatic bus_write(input logic a0, input logic [BW-1:0] d);
        @(negedge i_EMUCLK);
        i_cs_n = 1'b0;
        i_wr_n = 1'b0;
        i_a0   = a0;
        i_d    = d;
        repeat (4) @(negedge i_EMUCLK);
        i_cs_n = 1'b1;
        i_wr_n = 1'b1;
        repeat (5) @(negedge i_EMUCLK);
    endtask

    task automatic host_write(input logic [BW-1:0] addr, data);
        logic [2:0] ch;
        ch = addr[2:0];
        bus_write(1'b0, addr);
        bus_write(1'b1, data);
        case (addr[7:3]) // field positions of the channel bytes
            opm_reg_pkg::CH_RL_FL_ALG: begin
                m_rl[ch]  = data[7:6];
                m_fl[ch]  = data[5:3];
                m_alg[ch] = data[2:0];
            end
            opm_reg_pkg::CH_KC: m_kc[ch] = data[6:0];
            opm_reg_pkg::CH_KF: m_kf[ch] = data[7:2];
            opm_reg_pkg::CH_PMS_AMS: begin
                m_pms[ch] = data[6:4];
                m_ams[ch] = data[1:0];
            end
            default: ;
        endcase
    endtask

    task automatic status_read(input logic [1:0] flags, input logic [BW-1:0] exp);
        @(negedge i_EMUCLK);
        {i_timerb_flag, i_timera_flag} = flags;
        i_cs_n = 1'b0;
        i_rd_n = 1'b0;
        i_a0   = 1'b0;
        @(negedge i_EMUCLK);
        check_bit("o_d_oe", o_d_oe, 1'b1);
        check_byte("o_d", o_d, exp);
        i_cs_n = 1'b1;
        i_rd_n = 1'b1;
        @(negedge i_EMUCLK); // bus idle again
    endtask

    // walk two full rotations and compare every slot
    task automatic check_channels();
        logic [2:0] s;
        repeat (NUM_CH + 2) @(negedge i_EMUCLK);
        for (int i = 0; i < 2 * NUM_CH; i++) begin
            @(negedge i_EMUCLK);
            s = o_slot;
            check_field($sformatf("o_kc[%0d]", s), FW'(o_kc), FW'(m_kc[s]));
            check_field($sformatf("o_kf[%0d]", s), FW'(o_kf), FW'(m_kf[s]));
            check_field($sformatf("o_alg[%0d]", s), FW'(o_alg), FW'(m_alg[s]));
            check_field($sformatf("o_fl[%0d]", s), FW'(o_fl), FW'(m_fl[s]));
            check_field($sformatf("o_rl[%0d]", s), FW'(o_rl), FW'(m_rl[s]));
            check_field($sformatf("o_pms[%0d]", s), FW'(o_pms), FW'(m_pms[s]));
            check_field($sformatf("o_ams[%0d]", s), FW'(o_ams), FW'(m_ams[s]));
        end
    endtask

    task automatic check_global(input logic [BW-1:0] id, exp);
        case (id)
            opm_reg_pkg::ADDR_NOISE: begin
                check_bit("o_ne", o_ne, exp[7]);
                check_field("o_nfrq", FW'(o_nfrq), FW'(exp[4:0]));
            end
            opm_reg_pkg::ADDR_CLKA1: check_byte("o_clka1", o_clka1, exp);
            opm_reg_pkg::ADDR_CLKA2: check_field("o_clka2", FW'(o_clka2), FW'(exp[1:0]));
            opm_reg_pkg::ADDR_CLKB:  check_byte("o_clkb", o_clkb, exp);
            opm_reg_pkg::ADDR_TIMER_CTRL: begin
                check_bit("o_timera_run", o_timera_run, exp[0]);
                check_bit("o_timerb_run", o_timerb_run, exp[1]);
                check_bit("o_timera_irq_en", o_timera_irq_en, exp[2]);
                check_bit("o_timerb_irq_en", o_timerb_irq_en, exp[3]);
            end
            opm_reg_pkg::ADDR_LFRQ:      check_byte("o_lfrq", o_lfrq, exp);
            opm_reg_pkg::ADDR_LFO_DEPTH: check_field("o_pmd", o_pmd, exp[FW-1:0]);
            SEL_AMD:                     check_field("o_amd", o_amd, exp[FW-1:0]);
            opm_reg_pkg::ADDR_WAVE:      check_field("o_w", FW'(o_w), FW'(exp[1:0]));
            SEL_OE:                      check_bit("o_d_oe", o_d_oe, exp[0]);
            default: begin
                $display("unknown global check id %h", id);
                other_errors++;
            end
        endcase
    endtask

    task automatic load_cases();
        int fd;
        string line, cmd;
        logic [BW-1:0] a, v, e;
        fd = $fopen("tests/opm_reg_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file");
            other_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#" &&
                        $sscanf(line, "%s %h %h %h", cmd, a, v, e) == 4) begin
                    cmd_q.push_back(cmd);
                    a_q.push_back(a);
                    v_q.push_back(v);
                    e_q.push_back(e);
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////
    // case player

    initial begin
        {i_cs_n, i_rd_n, i_wr_n, i_a0} = 4'b1110;
        i_d = '0;
        {i_timera_flag, i_timerb_flag} = 2'b00;
        mrst_n = 1'b0;
        mismatches = 0;
        other_errors = 0;
        cycles = 0;
        limit = 0;
        cnt_frsta = 0;
        cnt_frstb = 0;
        cnt_lfrq = 0;
        base_frsta = 0;
        base_frstb = 0;
        base_lfrq = 0;
        seed = 61;
        for (int i = 0; i < NUM_CH; i++) begin
            {m_kc[i], m_kf[i], m_alg[i], m_fl[i]} = '0;
            {m_rl[i], m_pms[i], m_ams[i]} = '0;
        end
        load_cases();
        limit = cmd_q.size() * 64 + 500;
        repeat (4) @(negedge i_EMUCLK);
        mrst_n = 1'b1;

        for (int n = 0; n < cmd_q.size(); n++) begin
            case (cmd_q[n])
                "wr": host_write(a_q[n], v_q[n]);
                "rd": status_read(v_q[n][1:0], e_q[n]);
                "gl": check_global(a_q[n], e_q[n]);
                "ca": check_channels();
                "id": repeat (int'(v_q[n])) @(negedge i_EMUCLK);
                "rc": begin
                    // random bytes into all four blocks of one channel
                    host_write({opm_reg_pkg::CH_RL_FL_ALG, a_q[n][2:0]}, BW'($random(seed)));
                    host_write({opm_reg_pkg::CH_KC, a_q[n][2:0]}, BW'($random(seed)));
                    host_write({opm_reg_pkg::CH_KF, a_q[n][2:0]}, BW'($random(seed)));
                    host_write({opm_reg_pkg::CH_PMS_AMS, a_q[n][2:0]}, BW'($random(seed)));
                    check_channels();
                end
                "pc": begin
                    // each counter restarts from the point it was last checked
                    case (a_q[n])
                        8'h00: begin
                            check_byte("o_timera_frst count", BW'(cnt_frsta - base_frsta),
                                       e_q[n]);
                            base_frsta = cnt_frsta;
                        end
                        8'h01: begin
                            check_byte("o_timerb_frst count", BW'(cnt_frstb - base_frstb),
                                       e_q[n]);
                            base_frstb = cnt_frstb;
                        end
                        default: begin
                            check_byte("o_lfrq_update count", BW'(cnt_lfrq - base_lfrq),
                                       e_q[n]);
                            base_lfrq = cnt_lfrq;
                        end
                    endcase
                end
                default: begin
                    $display("unknown command %s in case %0d", cmd_q[n], n);
                    other_errors++;
                end
            endcase
        end

        $display("errors: %0d mismatches, %0d other, %0d assertion", mismatches, other_errors,
                 uut.u_chk.fail_cnt);
        if (mismatches == 0 && other_errors == 0 && uut.u_chk.fail_cnt == 0 &&
                cmd_q.size() != 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: opm_reg.f
verilog/opm_reg_pkg.sv
verilog/opm_wr_if.sv
verilog/opm_bus_sync.sv
verilog/opm_global_regs.sv
verilog/opm_channel_regs.sv
verilog/opm_reg.sv
tests/opm_reg_chk.sv
tests/opm_reg_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the opm_reg testbench with Verilator

set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --top-module opm_reg_tb \
    -f opm_reg.f \
    --Mdir obj_dir -o opm_reg_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/opm_reg_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// File: tests/opm_reg_cases.txt
# cmd addr value expect, all hex; wr write, rd status read with value as timer flags
# gl check global by address (1a amd, d0 oe), pc pulse count, rc random channel, ca channels
ca 00 00 00
gl 0f 00 00
gl 10 00 00
gl 11 00 00
gl 12 00 00
gl 14 00 00
gl 18 00 00
gl 19 00 00
gl 1a 00 00
gl 1b 00 00
gl d0 00 00
rd 00 00 00
wr 0f ff 00
gl 0f 00 9f
wr 10 a5 00
gl 10 00 a5
wr 11 ff 00
gl 11 00 03
wr 12 3c 00
gl 12 00 3c
wr 18 77 00
gl 18 00 77
pc 02 00 01
wr 1b fe 00
gl 1b 00 02
wr 05 55 00
gl 10 00 a5
gl 1b 00 02
wr 19 c5 00
gl 19 00 45
gl 1a 00 00
wr 19 2a 00
gl 19 00 45
gl 1a 00 2a
wr 14 3f 00
gl 14 00 0f
pc 00 00 01
pc 01 00 01
wr 14 13 00
gl 14 00 03
pc 00 00 01
pc 01 00 00
pc 02 00 00
rd 00 00 80
id 00 28 00
rd 00 03 03
rd 00 01 01
gl d0 00 00
rc 00 00 00
rc 01 00 00
rc 02 00 00
rc 03 00 00
rc 04 00 00
rc 05 00 00
rc 06 00 00
rc 07 00 00
ca 00 00 00
